/* sim/arb_patterns.txt */
# name chan vld_a vld_b id_a id_b addr_a addr_b rdy_a rdy_b exp_sel exp_id exp_flags, hex
# aw/ar: a = priority source, flags {valid,rdy_a,rdy_b}; b/r: a = response, {ready,tag,untag}
aw_both_hapb_wins   aw 1 1 123 0a5 1000     2000     1 0 1 923 6
aw_hppb_only        aw 0 1 123 0a5 1000     2000     1 0 0 0a5 5
aw_hppb_tag_clear   aw 0 1 000 fff 0        abcd     1 0 0 7ff 5
aw_backpressure     aw 1 1 03c 044 10       20       0 0 1 83c 4
aw_idle             aw 0 0 111 222 aaa      bbb      1 0 0 222 0
aw_hapb_only        aw 1 0 7ff 000 deadbeef 0        1 0 1 fff 6
ar_both_dst_wins    ar 1 1 010 020 cafe0000 beef0000 1 0 1 810 6
ar_hppb_only        ar 0 1 010 820 cafe0000 beef0000 1 0 0 020 5
ar_hppb_stall       ar 0 1 033 044 1        2        0 0 0 044 4
ar_dst_stall        ar 1 0 033 044 1        2        0 0 1 833 4
b_to_hapb           b  1 0 85a 000 0        0        1 1 1 05a 6
b_to_hppb           b  1 0 05a 000 0        0        1 1 0 05a 5
b_hapb_stall        b  1 0 8ff 000 0        0        0 1 1 0ff 2
b_hppb_stall        b  1 0 3ff 000 0        0        1 0 0 3ff 1
r_to_dst            r  1 0 c01 000 0        0        1 1 1 401 6
r_to_hppb           r  1 0 401 000 0        0        1 1 0 401 5
r_dst_stall         r  1 0 801 000 0        0        0 1 1 001 2
r_hppb_stall        r  1 0 001 000 0        0        1 0 0 001 1

/* compile.f */
verilog/hpp_arb_pkg.sv
verilog/write_arbiter.sv
verilog/read_arbiter.sv
verilog/resp_router.sv
verilog/hot_page_push_arbiter.sv
sim/tb_clock.sv
sim/hot_page_push_arbiter_properties.sv
sim/tb_hot_page_push_arbiter.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert --timescale 1ns/1ps
TOP      = tb_hot_page_push_arbiter
FILELIST = compile.f
LOG      = sim.log
FAIL_MSG = Checks failed
PASS_MSG = All checks passed

.PHONY: lint sim clean

lint:
	$(TOOL) --lint-only --timing --timescale 1ns/1ps --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation did not complete"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

/* sim/tb_hot_page_push_arbiter.sv */
/*
 * testbench for the hot page push arbiter
 * replays the pattern file on every channel and checks the DUT responses
 */
module tb_hot_page_push_arbiter import hpp_arb_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int unsigned SEED    = 32'h971e_976c;
    localparam int          NFIELD  = 11;   // hex columns per pattern line
    localparam int          W_LIMIT = 8;    // cycles allowed for a W beat

    logic axi4_mm_clk;
    logic rst;

    logic [ID_W-1:0]   awid, arid, bid, rid, hapb_awid, hapb_bid, hppb_awid, hppb_bid;
    logic [ID_W-1:0]   hppb_arid, hppb_rid, hppb_dst_arid, hppb_dst_rid;
    logic [ADDR_W-1:0] awaddr, araddr, hapb_awaddr, hppb_awaddr, hppb_araddr, hppb_dst_araddr;
    logic [USER_W-1:0] awuser, aruser, hapb_awuser, hppb_awuser, hppb_aruser, hppb_dst_aruser;
    logic [DATA_W-1:0] wdata, rdata, hapb_wdata, hppb_wdata, hppb_rdata, hppb_dst_rdata;
    logic [STRB_W-1:0] wstrb, hapb_wstrb, hppb_wstrb;
    logic [RESP_W-1:0] bresp, rresp, hapb_bresp, hppb_bresp, hppb_rresp, hppb_dst_rresp;
    logic awvalid, awready, wlast, wvalid, wready, bvalid, bready;
    logic arvalid, arready, rvalid, rready;
    logic hapb_awvalid, hapb_awready, hapb_wlast, hapb_wvalid, hapb_wready;
    logic hapb_bvalid, hapb_bready;
    logic hppb_awvalid, hppb_awready, hppb_wlast, hppb_wvalid, hppb_wready;
    logic hppb_bvalid, hppb_bready, hppb_arvalid, hppb_arready, hppb_rvalid, hppb_rready;
    logic hppb_dst_arvalid, hppb_dst_arready, hppb_dst_rvalid, hppb_dst_rready;

    string       t_name[$];
    string       t_chan[$];
    logic [63:0] t_fld[$];   // NFIELD values per test
    int          n_tests;
    bit          loaded;
    int          test_errs;
    int          total_errs;
    int          failed_tests;
    int          prop_fails;
    string       cur_name;

    // fields of the running test
    logic              va, vb, ra, rb, esel;
    logic [ID_W-1:0]   ida, idb, eid;
    logic [ADDR_W-1:0] aa, ab;
    logic [2:0]        eflags;

    tb_clock u_clock (.axi4_mm_clk(axi4_mm_clk));

    hot_page_push_arbiter u_dut (.*);

    task automatic check_value(input string what, input logic [63:0] exp,
                               input logic [63:0] act);
        assert (act === exp)
        else begin
            $display("** Error %s: %s expected %h actual %h", cur_name, what, exp, act);
            test_errs++;
        end
    endtask

    task automatic idle_inputs();
        {awready, wready, bvalid, arready, rvalid} = '0;
        {bid, bresp, rid, rdata, rresp} = '0;
        {hapb_awid, hapb_awaddr, hapb_awuser, hapb_awvalid} = '0;
        {hapb_wdata, hapb_wstrb, hapb_wlast, hapb_wvalid, hapb_bready} = '0;
        {hppb_awid, hppb_awaddr, hppb_awuser, hppb_awvalid} = '0;
        {hppb_wdata, hppb_wstrb, hppb_wlast, hppb_wvalid, hppb_bready} = '0;
        {hppb_arid, hppb_araddr, hppb_aruser, hppb_arvalid, hppb_rready} = '0;
        {hppb_dst_arid, hppb_dst_araddr, hppb_dst_aruser, hppb_dst_arvalid} = '0;
        hppb_dst_rready = 1'b0;
    endtask

    task automatic load_patterns();
        int          fd;
        int          n;
        string       line;
        string       nm;
        string       ch;
        logic [63:0] f [NFIELD];
        fd = $fopen("sim/arb_patterns.txt", "r");
        if (fd == 0) begin
            $display("cannot open pattern file sim/arb_patterns.txt");
            total_errs++;
            return;
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() > 1 && line[0] != "#") begin
                n = $sscanf(line, "%s %s %h %h %h %h %h %h %h %h %h %h %h", nm, ch,
                            f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9],
                            f[10]);
                if (n == NFIELD + 2) begin
                    t_name.push_back(nm);
                    t_chan.push_back(ch);
                    foreach (f[k])
                        t_fld.push_back(f[k]);
                end else begin
                    $display("malformed pattern line: %s", line);
                    total_errs++;
                end
            end
        end
        $fclose(fd);
        n_tests = t_name.size();
    endtask

    task automatic select_test(input int i);
        int b;
        b         = i * NFIELD;
        cur_name  = t_name[i];
        va        = t_fld[b][0];
        vb        = t_fld[b+1][0];
        ida       = t_fld[b+2][ID_W-1:0];
        idb       = t_fld[b+3][ID_W-1:0];
        aa        = t_fld[b+4];
        ab        = t_fld[b+5];
        ra        = t_fld[b+6][0];
        rb        = t_fld[b+7][0];
        esel      = t_fld[b+8][0];
        eid       = t_fld[b+9][ID_W-1:0];
        eflags    = t_fld[b+10][2:0];
        test_errs = 0;
    endtask

    // returns at the negedge where the W beat is about to be taken
    task automatic wait_w_handshake();
        int cycles;
        cycles = 0;
        while (!(wvalid && wready) && cycles < W_LIMIT) begin
            @(negedge axi4_mm_clk);
            cycles++;
        end
        assert (wvalid && wready)
        else begin
            $display("%s: no W handshake within %0d cycles", cur_name, W_LIMIT);
            test_errs++;
        end
    endtask

    task automatic run_aw();
        hapb_awvalid = va;
        hppb_awvalid = vb;
        hapb_awid    = ida;
        hppb_awid    = idb;
        hapb_awaddr  = aa;
        hppb_awaddr  = ab;
        hapb_awuser  = USER_W'($urandom);
        hppb_awuser  = ~hapb_awuser;   // never equal to the hapb user
        awready      = ra;
        @(negedge axi4_mm_clk);
        check_value("awvalid", 64'(eflags[2]), 64'(awvalid));
        check_value("hapb_awready", 64'(eflags[1]), 64'(hapb_awready));
        check_value("hppb_awready", 64'(eflags[0]), 64'(hppb_awready));
        check_value("awid", 64'(eid), 64'(awid));
        check_value("awaddr", esel ? aa : ab, awaddr);
        check_value("awuser", 64'(esel ? hapb_awuser : hppb_awuser), 64'(awuser));
        if (eflags[2] && ra) begin   // address taken, follow the data beat
            @(posedge axi4_mm_clk);
            #1;
            awready    = 1'b0;
            hapb_wdata = {$urandom, $urandom};
            hapb_wstrb = STRB_W'($urandom);
            hppb_wdata = {$urandom, $urandom};
            hppb_wstrb = STRB_W'($urandom);
            hapb_wlast = esel;   // only the owner flags its last beat
            hppb_wlast = !esel;
            {hapb_wvalid, hppb_wvalid} = 2'b11;
            wready     = 1'b1;
            @(negedge axi4_mm_clk);
            check_value("awvalid while locked", 64'd0, 64'(awvalid));
            check_value("wdata", esel ? hapb_wdata : hppb_wdata, wdata);
            check_value("wstrb", 64'(esel ? hapb_wstrb : hppb_wstrb), 64'(wstrb));
            check_value("wlast", 64'd1, 64'(wlast));
            check_value("owner wready", 64'd1, 64'(esel ? hapb_wready : hppb_wready));
            check_value("loser wready", 64'd0, 64'(esel ? hppb_wready : hapb_wready));
            wait_w_handshake();
            @(posedge axi4_mm_clk);
            #1;
            {hapb_wvalid, hppb_wvalid, wready} = 3'b000;
            @(negedge axi4_mm_clk);
            check_value("awvalid after W", 64'(va | vb), 64'(awvalid));
        end
    endtask

    task automatic run_ar();
        hppb_dst_arvalid = va;
        hppb_arvalid     = vb;
        hppb_dst_arid    = ida;
        hppb_arid        = idb;
        hppb_dst_araddr  = aa;
        hppb_araddr      = ab;
        hppb_dst_aruser  = USER_W'($urandom);
        hppb_aruser      = ~hppb_dst_aruser;
        arready          = ra;
        @(negedge axi4_mm_clk);
        check_value("arvalid", 64'(eflags[2]), 64'(arvalid));
        check_value("dst_arready", 64'(eflags[1]), 64'(hppb_dst_arready));
        check_value("hppb_arready", 64'(eflags[0]), 64'(hppb_arready));
        check_value("arid", 64'(eid), 64'(arid));
        check_value("araddr", esel ? aa : ab, araddr);
        check_value("aruser", 64'(esel ? hppb_dst_aruser : hppb_aruser), 64'(aruser));
    endtask

    task automatic run_b();
        bid         = ida;
        bvalid      = va;
        bresp       = RESP_W'($urandom);
        hapb_bready = ra;
        hppb_bready = rb;
        @(negedge axi4_mm_clk);
        check_value("bready", 64'(eflags[2]), 64'(bready));
        check_value("hapb_bvalid", 64'(eflags[1]), 64'(hapb_bvalid));
        check_value("hppb_bvalid", 64'(eflags[0]), 64'(hppb_bvalid));
        check_value("bid", 64'(eid), 64'(esel ? hapb_bid : hppb_bid));
        check_value("bresp", 64'(bresp), 64'(esel ? hapb_bresp : hppb_bresp));
    endtask

    task automatic run_r();
        rid             = ida;
        rvalid          = va;
        rdata           = {$urandom, $urandom};
        rresp           = RESP_W'($urandom);
        hppb_dst_rready = ra;
        hppb_rready     = rb;
        @(negedge axi4_mm_clk);
        check_value("rready", 64'(eflags[2]), 64'(rready));
        check_value("dst_rvalid", 64'(eflags[1]), 64'(hppb_dst_rvalid));
        check_value("hppb_rvalid", 64'(eflags[0]), 64'(hppb_rvalid));
        check_value("rid", 64'(eid), 64'(esel ? hppb_dst_rid : hppb_rid));
        check_value("rdata", rdata, esel ? hppb_dst_rdata : hppb_rdata);
        check_value("rresp", 64'(rresp), 64'(esel ? hppb_dst_rresp : hppb_rresp));
    endtask

    initial begin
        idle_inputs();
        rst = 1'b1;
        void'($urandom(SEED));
        load_patterns();
        loaded = 1'b1;
        repeat (10) @(posedge axi4_mm_clk);
        #1;
        rst = 1'b0;
        for (int i = 0; i < n_tests; i++) begin
            @(posedge axi4_mm_clk);
            #1;   // drive just after the edge
            idle_inputs();
            select_test(i);
            if (t_chan[i] == "aw") begin
                run_aw();
            end else if (t_chan[i] == "ar") begin
                run_ar();
            end else if (t_chan[i] == "b") begin
                run_b();
            end else if (t_chan[i] == "r") begin
                run_r();
            end else begin
                $display("%s: unknown channel %s", cur_name, t_chan[i]);
                test_errs++;
            end
            total_errs += test_errs;
            if (test_errs != 0)
                failed_tests++;
            $display("test %s: %s", cur_name, (test_errs == 0) ? "ok" : "FAILED");
        end
        prop_fails = u_dut.u_write_arbiter.u_props.fail_count;
        $display("%0d tests, %0d failed, %0d errors, %0d property failures",
                 n_tests, failed_tests, total_errs, prop_fails);
        if (total_errs == 0 && prop_fails == 0 && n_tests > 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    // run limit scales with the pattern count
    initial begin
        wait (loaded);
        repeat (n_tests * 20 + 100) @(posedge axi4_mm_clk);
        $display("timeout: tests did not finish within %0d cycles", n_tests * 20 + 100);
        $display("Checks failed");
        $finish;
    end

endmodule

/* sim/hot_page_push_arbiter_properties.sv */
/*
 * write arbiter properties
 * AW and W exclusion, lock release on the W beat, single AW grant
 */
module hot_page_push_arbiter_properties import hpp_arb_pkg::*; (
    input logic axi4_mm_clk,
    input logic rst,
    input logic awvalid,
    input logic wvalid,
    input logic wready,
    input logic wr_lock,
    input logic hapb_awready,
    input logic hppb_awready
);
    timeunit 1ns;
    timeprecision 1ps;

    int fail_count = 0;   // read by the testbench top

    aw_w_exclusive: assert property (@(posedge axi4_mm_clk) disable iff (rst)
        !(awvalid && wvalid))
    else begin
        $error("awvalid and wvalid high in the same cycle");
        fail_count++;
    end

    // lock only drops on an accepted data beat
    lock_held: assert property (@(posedge axi4_mm_clk) disable iff (rst)
        wr_lock && !(wvalid && wready) |=> wr_lock)
    else begin
        $error("write lock cleared without a W handshake");
        fail_count++;
    end

    single_aw_grant: assert property (@(posedge axi4_mm_clk) disable iff (rst)
        !(hapb_awready && hppb_awready))
    else begin
        $error("both AW sources granted at once");
        fail_count++;
    end

endmodule

bind write_arbiter hot_page_push_arbiter_properties u_props (
    .axi4_mm_clk  (axi4_mm_clk),
    .rst          (rst),
    .awvalid      (awvalid),
    .wvalid       (wvalid),
    .wready       (wready),
    .wr_lock      (wr_lock),
    .hapb_awready (hapb_awready),
    .hppb_awready (hppb_awready)
);

/* sim/tb_clock.sv */
/*
 * testbench clock source, 4 ns period
 */
module tb_clock (
    output logic axi4_mm_clk
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam time HALF_PERIOD = 2ns;

    initial begin
        axi4_mm_clk = 1'b0;
        forever #HALF_PERIOD axi4_mm_clk = ~axi4_mm_clk;
    end

endmodule

/* verilog/hot_page_push_arbiter.sv */
/*
 * hot page push arbiter top
 * shares one AXI4 write and one read port between the migration sources
 */
module hot_page_push_arbiter import hpp_arb_pkg::*; (
    input  logic              axi4_mm_clk,
    input  logic              rst,

    // AXI master side
    output logic [ID_W-1:0]   awid,
    output logic [ADDR_W-1:0] awaddr,
    output logic [USER_W-1:0] awuser,
    output logic              awvalid,
    input  logic              awready,
    output logic [DATA_W-1:0] wdata,
    output logic [STRB_W-1:0] wstrb,
    output logic              wlast,
    output logic              wvalid,
    input  logic              wready,
    input  logic [ID_W-1:0]   bid,
    input  logic [RESP_W-1:0] bresp,
    input  logic              bvalid,
    output logic              bready,
    output logic [ID_W-1:0]   arid,
    output logic [ADDR_W-1:0] araddr,
    output logic [USER_W-1:0] aruser,
    output logic              arvalid,
    input  logic              arready,
    input  logic [ID_W-1:0]   rid,
    input  logic [DATA_W-1:0] rdata,
    input  logic [RESP_W-1:0] rresp,
    input  logic              rvalid,
    output logic              rready,

    // hot address pusher, write only
    input  logic [ID_W-1:0]   hapb_awid,
    input  logic [ADDR_W-1:0] hapb_awaddr,
    input  logic [USER_W-1:0] hapb_awuser,
    input  logic              hapb_awvalid,
    output logic              hapb_awready,
    input  logic [DATA_W-1:0] hapb_wdata,
    input  logic [STRB_W-1:0] hapb_wstrb,
    input  logic              hapb_wlast,
    input  logic              hapb_wvalid,
    output logic              hapb_wready,
    output logic [ID_W-1:0]   hapb_bid,
    output logic [RESP_W-1:0] hapb_bresp,
    output logic              hapb_bvalid,
    input  logic              hapb_bready,

    // hot page pusher
    input  logic [ID_W-1:0]   hppb_awid,
    input  logic [ADDR_W-1:0] hppb_awaddr,
    input  logic [USER_W-1:0] hppb_awuser,
    input  logic              hppb_awvalid,
    output logic              hppb_awready,
    input  logic [DATA_W-1:0] hppb_wdata,
    input  logic [STRB_W-1:0] hppb_wstrb,
    input  logic              hppb_wlast,
    input  logic              hppb_wvalid,
    output logic              hppb_wready,
    output logic [ID_W-1:0]   hppb_bid,
    output logic [RESP_W-1:0] hppb_bresp,
    output logic              hppb_bvalid,
    input  logic              hppb_bready,
    input  logic [ID_W-1:0]   hppb_arid,
    input  logic [ADDR_W-1:0] hppb_araddr,
    input  logic [USER_W-1:0] hppb_aruser,
    input  logic              hppb_arvalid,
    output logic              hppb_arready,
    output logic [ID_W-1:0]   hppb_rid,
    output logic [DATA_W-1:0] hppb_rdata,
    output logic [RESP_W-1:0] hppb_rresp,
    output logic              hppb_rvalid,
    input  logic              hppb_rready,

    // destination fetcher, read only
    input  logic [ID_W-1:0]   hppb_dst_arid,
    input  logic [ADDR_W-1:0] hppb_dst_araddr,
    input  logic [USER_W-1:0] hppb_dst_aruser,
    input  logic              hppb_dst_arvalid,
    output logic              hppb_dst_arready,
    output logic [ID_W-1:0]   hppb_dst_rid,
    output logic [DATA_W-1:0] hppb_dst_rdata,
    output logic [RESP_W-1:0] hppb_dst_rresp,
    output logic              hppb_dst_rvalid,
    input  logic              hppb_dst_rready
);

    logic [DATA_W+RESP_W-1:0] dst_r_payload;    // {rdata, rresp}
    logic [DATA_W+RESP_W-1:0] hppb_r_payload;

    assign {hppb_dst_rdata, hppb_dst_rresp} = dst_r_payload;
    assign {hppb_rdata, hppb_rresp}         = hppb_r_payload;

    write_arbiter u_write_arbiter (
        .axi4_mm_clk  (axi4_mm_clk),
        .rst          (rst),
        .hapb_awid    (hapb_awid),
        .hapb_awaddr  (hapb_awaddr),
        .hapb_awuser  (hapb_awuser),
        .hapb_awvalid (hapb_awvalid),
        .hapb_awready (hapb_awready),
        .hapb_wdata   (hapb_wdata),
        .hapb_wstrb   (hapb_wstrb),
        .hapb_wlast   (hapb_wlast),
        .hapb_wvalid  (hapb_wvalid),
        .hapb_wready  (hapb_wready),
        .hppb_awid    (hppb_awid),
        .hppb_awaddr  (hppb_awaddr),
        .hppb_awuser  (hppb_awuser),
        .hppb_awvalid (hppb_awvalid),
        .hppb_awready (hppb_awready),
        .hppb_wdata   (hppb_wdata),
        .hppb_wstrb   (hppb_wstrb),
        .hppb_wlast   (hppb_wlast),
        .hppb_wvalid  (hppb_wvalid),
        .hppb_wready  (hppb_wready),
        .awid         (awid),
        .awaddr       (awaddr),
        .awuser       (awuser),
        .awvalid      (awvalid),
        .awready      (awready),
        .wdata        (wdata),
        .wstrb        (wstrb),
        .wlast        (wlast),
        .wvalid       (wvalid),
        .wready       (wready)
    );

    read_arbiter u_read_arbiter (
        .dst_arid     (hppb_dst_arid),
        .dst_araddr   (hppb_dst_araddr),
        .dst_aruser   (hppb_dst_aruser),
        .dst_arvalid  (hppb_dst_arvalid),
        .dst_arready  (hppb_dst_arready),
        .hppb_arid    (hppb_arid),
        .hppb_araddr  (hppb_araddr),
        .hppb_aruser  (hppb_aruser),
        .hppb_arvalid (hppb_arvalid),
        .hppb_arready (hppb_arready),
        .arid         (arid),
        .araddr       (araddr),
        .aruser       (aruser),
        .arvalid      (arvalid),
        .arready      (arready)
    );

    // B goes back to hapb when tagged
    resp_router #(.PAYLOAD_W(RESP_W)) u_b_router (
        .id            (bid),
        .payload       (bresp),
        .valid         (bvalid),
        .ready         (bready),
        .tag_id        (hapb_bid),
        .tag_payload   (hapb_bresp),
        .tag_valid     (hapb_bvalid),
        .tag_ready     (hapb_bready),
        .untag_id      (hppb_bid),
        .untag_payload (hppb_bresp),
        .untag_valid   (hppb_bvalid),
        .untag_ready   (hppb_bready)
    );

    // R goes back to the dst fetcher when tagged
    resp_router #(.PAYLOAD_W(DATA_W + RESP_W)) u_r_router (
        .id            (rid),
        .payload       ({rdata, rresp}),
        .valid         (rvalid),
        .ready         (rready),
        .tag_id        (hppb_dst_rid),
        .tag_payload   (dst_r_payload),
        .tag_valid     (hppb_dst_rvalid),
        .tag_ready     (hppb_dst_rready),
        .untag_id      (hppb_rid),
        .untag_payload (hppb_r_payload),
        .untag_valid   (hppb_rvalid),
        .untag_ready   (hppb_rready)
    );

endmodule

/* verilog/resp_router.sv */
/*
 * response router, splits one AXI response channel over two sinks
 * selected by the ID tag bit, tag bit cleared on the way back
 */
module resp_router import hpp_arb_pkg::*; #(
    parameter int PAYLOAD_W = RESP_W
) (
    input  logic [ID_W-1:0]      id,
    input  logic [PAYLOAD_W-1:0] payload,
    input  logic                 valid,
    output logic                 ready,

    output logic [ID_W-1:0]      tag_id,
    output logic [PAYLOAD_W-1:0] tag_payload,
    output logic                 tag_valid,
    input  logic                 tag_ready,

    output logic [ID_W-1:0]      untag_id,
    output logic [PAYLOAD_W-1:0] untag_payload,
    output logic                 untag_valid,
    input  logic                 untag_ready
);

    logic            is_tag;
    logic [ID_W-1:0] id_clr;   // id with the tag bit removed

    assign is_tag = id[ID_TAG_BIT];

    always_comb begin
        id_clr = id;
        id_clr[ID_TAG_BIT] = 1'b0;
    end

    assign tag_id        = id_clr;
    assign tag_payload   = payload;
    assign tag_valid     = valid && is_tag;
    assign untag_id      = id_clr;
    assign untag_payload = payload;
    assign untag_valid   = valid && !is_tag;

    // back-pressure from whichever sink the ID selects
    assign ready = is_tag ? tag_ready : untag_ready;

endmodule

/* verilog/read_arbiter.sv */
/*
 * read arbiter, dst fetcher over hppb on AR
 * winner is tagged in the ID so the R channel can be routed back
 */
module read_arbiter import hpp_arb_pkg::*; (
    input  logic [ID_W-1:0]   dst_arid,
    input  logic [ADDR_W-1:0] dst_araddr,
    input  logic [USER_W-1:0] dst_aruser,
    input  logic              dst_arvalid,
    output logic              dst_arready,

    input  logic [ID_W-1:0]   hppb_arid,
    input  logic [ADDR_W-1:0] hppb_araddr,
    input  logic [USER_W-1:0] hppb_aruser,
    input  logic              hppb_arvalid,
    output logic              hppb_arready,

    output logic [ID_W-1:0]   arid,
    output logic [ADDR_W-1:0] araddr,
    output logic [USER_W-1:0] aruser,
    output logic              arvalid,
    input  logic              arready
);

    always_comb begin
        if (dst_arvalid) begin
            arid   = dst_arid;
            araddr = dst_araddr;
            aruser = dst_aruser;
        end else begin
            arid   = hppb_arid;
            araddr = hppb_araddr;
            aruser = hppb_aruser;
        end
        arid[ID_TAG_BIT] = dst_arvalid;   // 1 marks dst

        arvalid      = dst_arvalid || hppb_arvalid;
        dst_arready  = arready && dst_arvalid;
        hppb_arready = arready && !dst_arvalid;
    end

endmodule

/* verilog/write_arbiter.sv */
/*
 * write arbiter, hapb over hppb on AW
 * W channel stays locked to the AW winner until its single beat is accepted
 */
module write_arbiter import hpp_arb_pkg::*; (
    input  logic              axi4_mm_clk,
    input  logic              rst,

    input  logic [ID_W-1:0]   hapb_awid,
    input  logic [ADDR_W-1:0] hapb_awaddr,
    input  logic [USER_W-1:0] hapb_awuser,
    input  logic              hapb_awvalid,
    output logic              hapb_awready,
    input  logic [DATA_W-1:0] hapb_wdata,
    input  logic [STRB_W-1:0] hapb_wstrb,
    input  logic              hapb_wlast,
    input  logic              hapb_wvalid,
    output logic              hapb_wready,

    input  logic [ID_W-1:0]   hppb_awid,
    input  logic [ADDR_W-1:0] hppb_awaddr,
    input  logic [USER_W-1:0] hppb_awuser,
    input  logic              hppb_awvalid,
    output logic              hppb_awready,
    input  logic [DATA_W-1:0] hppb_wdata,
    input  logic [STRB_W-1:0] hppb_wstrb,
    input  logic              hppb_wlast,
    input  logic              hppb_wvalid,
    output logic              hppb_wready,

    output logic [ID_W-1:0]   awid,
    output logic [ADDR_W-1:0] awaddr,
    output logic [USER_W-1:0] awuser,
    output logic              awvalid,
    input  logic              awready,

    output logic [DATA_W-1:0] wdata,
    output logic [STRB_W-1:0] wstrb,
    output logic              wlast,
    output logic              wvalid,
    input  logic              wready
);

    logic      wr_lock;    // address accepted, data beat pending
    wr_owner_e wr_owner;
    wr_owner_e aw_owner;   // current AW winner

    assign aw_owner = hapb_awvalid ? OWNER_HAPB : OWNER_HPPB;

    // address channel, fixed priority, closed while a data beat is pending
    always_comb begin
        if (aw_owner == OWNER_HAPB) begin
            awid   = hapb_awid;
            awaddr = hapb_awaddr;
            awuser = hapb_awuser;
        end else begin
            awid   = hppb_awid;
            awaddr = hppb_awaddr;
            awuser = hppb_awuser;
        end
        awid[ID_TAG_BIT] = (aw_owner == OWNER_HAPB);

        awvalid      = !wr_lock && (hapb_awvalid || hppb_awvalid);
        hapb_awready = !wr_lock && awready && (aw_owner == OWNER_HAPB);
        hppb_awready = !wr_lock && awready && hppb_awvalid && (aw_owner == OWNER_HPPB);
    end

    // data channel follows the registered owner
    always_comb begin
        if (wr_owner == OWNER_HAPB) begin
            wdata = hapb_wdata;
            wstrb = hapb_wstrb;
            wlast = hapb_wlast;
            wvalid = wr_lock && hapb_wvalid;
        end else begin
            wdata = hppb_wdata;
            wstrb = hppb_wstrb;
            wlast = hppb_wlast;
            wvalid = wr_lock && hppb_wvalid;
        end
        hapb_wready = wr_lock && wready && (wr_owner == OWNER_HAPB);
        hppb_wready = wr_lock && wready && (wr_owner == OWNER_HPPB);
    end

    always_ff @(posedge axi4_mm_clk) begin
        if (rst) begin
            wr_lock  <= 1'b0;
            wr_owner <= OWNER_HPPB;
        end else if (awvalid && awready) begin
            wr_lock  <= 1'b1;
            wr_owner <= aw_owner;
        end else if (wvalid && wready) begin
            wr_lock  <= 1'b0;   // beat taken, reopen AW
        end
    end

endmodule

/* verilog/hpp_arb_pkg.sv */
/*
 * hot page push arbiter package
 * AXI field widths, ID tag position and write owner type
 */
package hpp_arb_pkg;

    localparam int ID_W   = 12;
    localparam int ADDR_W = 64;
    localparam int DATA_W = 64;
    localparam int STRB_W = DATA_W / 8;   // one strobe per byte
    localparam int USER_W = 6;
    localparam int RESP_W = 2;

    // set on requests from hapb (write) or dst (read)
    localparam int ID_TAG_BIT = 11;

    // source holding the write data channel
    typedef enum logic {
        OWNER_HPPB = 1'b0,
        OWNER_HAPB = 1'b1
    } wr_owner_e;

endpackage
